// ==== mesh_router.f ====
+incdir+.
mesh_router_pkg.sv
mesh_node_cfg.sv
mesh_in_port.sv
mesh_out_arb.sv
mesh_router.sv
mesh_router_chk.sv
mesh_router_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the mesh router testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module mesh_router_tb \
  -f mesh_router.f \
  -o mesh_router_sim

sim_out=$(./obj_dir/mesh_router_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// ==== mesh_router_tb.sv ====
`timescale 1ns/100ps

`include "mesh_router_config.svh"

module mesh_router_tb;
  import mesh_router_pkg::*;

  localparam int NP     = `MR_NUM_PORTS;
  localparam int N_STIM = 9;
  localparam int T_CLK  = 40;

  // One row of the stimulus table
  typedef struct packed {
    logic [2:0]            src;
    logic [`MR_ADDR_W-1:0] dst_x;
    logic [`MR_ADDR_W-1:0] dst_y;
    logic [7:0]            len;        // Flits per packet with the header
    logic [3:0]            reps;
    logic                  cfg_wr;     // Write a new node address first
    logic [`MR_ADDR_W-1:0] cfg_x;
    logic [`MR_ADDR_W-1:0] cfg_y;
    logic [6:0]            ready_pct;  // Output ready probability
    logic                  with_next;  // Runs alongside the next row
    logic                  want_full;
  } stim_t;

  logic          clk;
  logic          rst_n;
  logic          cfg_wr;
  node_addr_t    cfg_addr;
  flit_t         in_flit  [NP];
  logic [NP-1:0] in_valid;
  logic [NP-1:0] in_ready;
  flit_t         out_flit [NP];
  logic [NP-1:0] out_valid;
  logic [NP-1:0] out_ready;

  stim_t         stim      [N_STIM];
  string         test_name [N_STIM];
  logic          stim_built;
  int            ready_pct;
  logic [NP-1:0] full_seen;
  logic [31:0]   run_cnt;  // Payload count shared by all inputs
  logic [15:0]   pkt_seq;
  int            chk_errors;
  int            chk_pending;
  int            chk_checked;
  int            tb_errors;

  mesh_router DUT (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_cfg_wr    (cfg_wr),
    .i_cfg_addr  (cfg_addr),
    .i_in_flit   (in_flit),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .o_out_flit  (out_flit),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready)
  );

  mesh_router_chk u_chk (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_cfg_wr    (cfg_wr),
    .i_cfg_addr  (cfg_addr),
    .i_in_flit   (in_flit),
    .i_in_valid  (in_valid),
    .i_in_ready  (in_ready),
    .i_out_flit  (out_flit),
    .i_out_valid (out_valid),
    .i_out_ready (out_ready),
    .o_errors    (chk_errors),
    .o_pending   (chk_pending),
    .o_checked   (chk_checked)
  );

  initial begin
    clk = 1'b0;
    forever #(T_CLK/2) clk = ~clk;
  end

  // Random output back-pressure
  initial begin : ready_gen
    void'($urandom(32'h879461f9));
    forever begin
      @(negedge clk);
      for (int j = 0; j < NP; j++)
        out_ready[j] = ($urandom % 100) < ready_pct;
    end
  end

  function automatic stim_t make_row(input port_e src, input int dx, input int dy,
                                     input int len, input int reps, input int pct);
    stim_t r;
    r           = '0;
    r.src       = src;
    r.dst_x     = `MR_ADDR_W'(dx);
    r.dst_y     = `MR_ADDR_W'(dy);
    r.len       = 8'(len);
    r.reps      = 4'(reps);
    r.ready_pct = 7'(pct);
    return r;
  endfunction

  // ----------------------------------------
  // Stimulus table for a node at (1,2)
  // ----------------------------------------
  task automatic fill_stimulus();
    test_name[0] = "local_delivery";
    stim[0]      = make_row(PORT_WST, 1, 2, 3, 2, 100);
    test_name[1] = "x_first_east";
    stim[1]      = make_row(PORT_TER, 3, 0, 4, 1, 100);
    test_name[2] = "x_first_west";
    stim[2]      = make_row(PORT_TER, 0, 3, 2, 2, 100);
    test_name[3] = "y_north";
    stim[3]      = make_row(PORT_WST, 1, 0, 3, 1, 100);
    test_name[4] = "y_south";
    stim[4]      = make_row(PORT_WST, 1, 3, 1, 3, 100);
    test_name[5] = "contention_wst";
    stim[5]      = make_row(PORT_WST, 1, 2, 6, 2, 100);
    stim[5].with_next = 1'b1;
    test_name[6] = "contention_est";
    stim[6]      = make_row(PORT_EST, 1, 2, 6, 2, 100);
    test_name[7] = "backpressure";
    stim[7]      = make_row(PORT_TER, 1, 3, 16, 2, 10);
    stim[7].want_full = 1'b1;
    test_name[8] = "cfg_new_addr";  // Old local address lies west of the new one
    stim[8]      = make_row(PORT_TER, 1, 2, 3, 1, 100);
    stim[8].cfg_wr = 1'b1;
    stim[8].cfg_x  = `MR_ADDR_W'(2);
    stim[8].cfg_y  = `MR_ADDR_W'(2);
  endtask

  function automatic int total_flits();
    int n;
    n = 0;
    for (int k = 0; k < N_STIM; k++)
      n += int'(stim[k].len) * int'(stim[k].reps);
    return n;
  endfunction

  task automatic write_node_addr(input logic [`MR_ADDR_W-1:0] x,
                                 input logic [`MR_ADDR_W-1:0] y);
    @(negedge clk);
    cfg_addr.x = x;
    cfg_addr.y = y;
    cfg_wr     = 1'b1;
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  task automatic send_packets(input int k);
    stim_t s;
    int    p;
    flit_t fl;
    s = stim[k];
    p = int'(s.src);
    for (int r = 0; r < int'(s.reps); r++) begin
      pkt_seq = pkt_seq + 1'b1;
      for (int f = 0; f < int'(s.len); f++) begin
        @(negedge clk);
        fl = '0;
        if (f == 0) begin
          fl.data[`MR_HDR_X_LSB +: `MR_ADDR_W] = s.dst_x;
          fl.data[`MR_HDR_Y_LSB +: `MR_ADDR_W] = s.dst_y;
          fl.data[`MR_HDR_SRC_LSB +: 4]        = 4'(p);
          fl.data[`MR_DATA_W-1 -: 16]          = pkt_seq;
        end else begin
          run_cnt = run_cnt + 1;
          fl.data = run_cnt;
        end
        fl.last     = (f == int'(s.len) - 1);
        in_flit[p]  = fl;
        in_valid[p] = 1'b1;
        // Transfer on the next rising edge once ready is up
        while (!in_ready[p]) begin
          full_seen[p] = 1'b1;
          @(negedge clk);
        end
      end
    end
    @(negedge clk);
    in_valid[p] = 1'b0;
  endtask

  task automatic wait_drained(input int max_cyc, input string label);
    int n;
    n = 0;
    while (chk_pending != 0 && n < max_cyc) begin
      @(negedge clk);
      n++;
    end
    if (chk_pending != 0) begin
      $display("%s: %0d flits left over after %0d cycles", label, chk_pending, max_cyc);
      tb_errors++;
    end
  endtask

  initial begin : watchdog
    int limit;
    wait (stim_built === 1'b1);
    limit = total_flits() * 20 + 1000;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not complete within %0d clock cycles", limit);
    $display("TEST FAILED");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main
    int    k;
    int    step;
    int    errs_before;
    int    budget;
    int    n_tests;
    int    n_failed;
    string label;
    stim_t s;
    rst_n      = 1'b0;
    cfg_wr     = 1'b0;
    cfg_addr   = '0;
    in_valid   = '0;
    out_ready  = '1;
    ready_pct  = 100;
    full_seen  = '0;
    run_cnt    = '0;
    pkt_seq    = '0;
    tb_errors  = 0;
    stim_built = 1'b0;
    n_tests    = 0;
    n_failed   = 0;
    for (int p = 0; p < NP; p++)
      in_flit[p] = '0;
    fill_stimulus();
    stim_built = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    k = 0;
    while (k < N_STIM) begin
      s           = stim[k];
      errs_before = chk_errors + tb_errors;
      ready_pct   = int'(s.ready_pct);
      full_seen   = '0;
      if (s.cfg_wr)
        write_node_addr(s.cfg_x, s.cfg_y);
      budget = int'(s.len) * int'(s.reps);
      if (s.with_next && k + 1 < N_STIM) begin
        label  = {test_name[k], " + ", test_name[k+1]};
        budget = budget + int'(stim[k+1].len) * int'(stim[k+1].reps);
        step   = 2;
        fork  // Both inputs compete for one output
          send_packets(k);
          send_packets(k + 1);
        join
      end else begin
        label = test_name[k];
        step  = 1;
        send_packets(k);
      end
      wait_drained(budget * 20 + 200, label);
      if (s.want_full && !full_seen[s.src]) begin
        $display("%s: input ready never dropped while the output was stalled", label);
        tb_errors++;
      end
      ready_pct = 100;
      repeat (2) @(negedge clk);
      n_tests++;
      if (chk_errors + tb_errors == errs_before) begin
        $display("[%0t] %s: pass", $time, label);
      end else begin
        n_failed++;
        $display("[%0t] %s: fail, %0d errors", $time, label,
                 chk_errors + tb_errors - errs_before);
      end
      k += step;
    end
    $display("Summary: %0d tests, %0d failed, %0d flits checked, %0d errors",
             n_tests, n_failed, chk_checked, chk_errors + tb_errors);
    if (n_failed == 0 && chk_errors + tb_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== mesh_router_chk.sv ====
`timescale 1ns/100ps

`include "mesh_router_config.svh"

module mesh_router_chk (
  input  logic                        clk,
  input  logic                        i_rst_n,
  input  logic                        i_cfg_wr,
  input  mesh_router_pkg::node_addr_t i_cfg_addr,
  input  mesh_router_pkg::flit_t      i_in_flit [`MR_NUM_PORTS],
  input  logic [`MR_NUM_PORTS-1:0]    i_in_valid,
  input  logic [`MR_NUM_PORTS-1:0]    i_in_ready,
  input  mesh_router_pkg::flit_t      i_out_flit [`MR_NUM_PORTS],
  input  logic [`MR_NUM_PORTS-1:0]    i_out_valid,
  input  logic [`MR_NUM_PORTS-1:0]    i_out_ready,
  output int                          o_errors,
  output int                          o_pending,  // Accepted but not yet delivered
  output int                          o_checked
);
  import mesh_router_pkg::*;

  localparam int NP = `MR_NUM_PORTS;

  node_addr_t addr;               // Reset value or last config write
  flit_t      exp_q [NP*NP][$];   // Indexed by output * NP + source
  int         in_route [NP];
  logic       in_busy  [NP];      // Input is inside a packet
  int         out_src  [NP];
  logic       out_busy [NP];

  // X first, then Y, local when both match
  function automatic int expected_port(input flit_t hdr, input node_addr_t a);
    logic [`MR_ADDR_W-1:0] dx;
    logic [`MR_ADDR_W-1:0] dy;
    dx = hdr.data[`MR_HDR_X_LSB +: `MR_ADDR_W];
    dy = hdr.data[`MR_HDR_Y_LSB +: `MR_ADDR_W];
    if (dx == a.x && dy == a.y)
      return int'(PORT_TER);
    if (dx != a.x)
      return (dx < a.x) ? int'(PORT_WST) : int'(PORT_EST);
    return (dy < a.y) ? int'(PORT_NOR) : int'(PORT_SOU);
  endfunction

  // ----------------------------------------
  // Transfers on the rising edge
  // ----------------------------------------
  always @(posedge clk) begin : watch
    flit_t f;
    flit_t e;
    int    k;
    if (!i_rst_n) begin
      addr.x = `MR_ADDR_W'(`MR_RESET_X);
      addr.y = `MR_ADDR_W'(`MR_RESET_Y);
      for (int p = 0; p < NP; p++) begin
        in_busy[p]  = 1'b0;
        out_busy[p] = 1'b0;
      end
    end else begin
      for (int i = 0; i < NP; i++) begin
        if (i_in_valid[i] && i_in_ready[i]) begin
          f = i_in_flit[i];
          if (!in_busy[i])
            in_route[i] = expected_port(f, addr);  // Header picks the queue
          in_busy[i] = !f.last;
          exp_q[in_route[i]*NP + i].push_back(f);
          o_pending++;
        end
      end
      for (int j = 0; j < NP; j++) begin
        if (i_out_valid[j] && i_out_ready[j]) begin
          f = i_out_flit[j];
          if (!out_busy[j])
            out_src[j] = int'(f.data[`MR_HDR_SRC_LSB +: 4]);
          out_busy[j] = !f.last;
          if (out_src[j] >= NP) begin
            $display("Output %0d delivered a header with unknown source tag %0d",
                     j, out_src[j]);
            o_errors++;
          end else begin
            k = j*NP + out_src[j];
            if (exp_q[k].size() == 0) begin
              $display("Unexpected flit %h on output %0d, no flit from input %0d was due",
                       f.data, j, out_src[j]);
              o_errors++;
            end else begin
              e = exp_q[k].pop_front();
              o_pending--;
              o_checked++;
              if (f.data !== e.data) begin
                $display("CHECK FAILED o_out_flit[%0d].data expected %h got %h",
                         j, e.data, f.data);
                o_errors++;
              end
              if (f.last !== e.last) begin
                $display("CHECK FAILED o_out_flit[%0d].last expected %h got %h",
                         j, e.last, f.last);
                o_errors++;
              end
            end
          end
        end
      end
      if (i_cfg_wr)
        addr = i_cfg_addr;  // Applies to later headers
    end
  end

endmodule

// ==== mesh_router.sv ====
`timescale 1ns/100ps

`include "mesh_router_config.svh"

module mesh_router (
  input  logic                        clk,
  input  logic                        i_rst_n,
  // Node address writes
  input  logic                        i_cfg_wr,
  input  mesh_router_pkg::node_addr_t i_cfg_addr,
  // Input links, indexed by port_e
  input  mesh_router_pkg::flit_t      i_in_flit [`MR_NUM_PORTS],
  input  logic [`MR_NUM_PORTS-1:0]    i_in_valid,
  output logic [`MR_NUM_PORTS-1:0]    o_in_ready,
  // Output links, indexed by port_e
  output mesh_router_pkg::flit_t      o_out_flit [`MR_NUM_PORTS],
  output logic [`MR_NUM_PORTS-1:0]    o_out_valid,
  input  logic [`MR_NUM_PORTS-1:0]    i_out_ready
);
  import mesh_router_pkg::*;

  localparam int NP = `MR_NUM_PORTS;

  node_addr_t      node_addr;
  flit_t           heads   [NP];
  logic [NP-1:0]   req     [NP];  // [input][output]
  logic [NP-1:0]   req_t   [NP];  // [output][input]
  logic [NP-1:0]   grant   [NP];  // [output][input]
  logic [NP-1:0]   grant_t [NP];  // [input][output]
  logic [NP-1:0]   pop;

  mesh_node_cfg u_cfg (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cfg_wr    (i_cfg_wr),
    .i_cfg_addr  (i_cfg_addr),
    .o_node_addr (node_addr)
  );

  // ----------------------------------------
  // Input ports
  // ----------------------------------------
  for (genvar i = 0; i < NP; i++) begin : g_in
    mesh_in_port u_in (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_flit      (i_in_flit[i]),
      .i_valid     (i_in_valid[i]),
      .o_ready     (o_in_ready[i]),
      .i_node_addr (node_addr),
      .o_head      (heads[i]),
      .o_req       (req[i]),
      .i_pop       (pop[i])
    );
    assign pop[i] = |grant_t[i];  // Only the requested output can grant
  end

  // Transpose requests to outputs and grants back to inputs
  for (genvar i = 0; i < NP; i++) begin : g_row
    for (genvar j = 0; j < NP; j++) begin : g_col
      assign req_t[j][i]   = req[i][j];
      assign grant_t[i][j] = grant[j][i];
    end
  end

  // ----------------------------------------
  // Output arbiters
  // ----------------------------------------
  for (genvar j = 0; j < NP; j++) begin : g_out
    mesh_out_arb u_arb (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_req   (req_t[j]),
      .i_heads (heads),
      .o_grant (grant[j]),
      .o_flit  (o_out_flit[j]),
      .o_valid (o_out_valid[j]),
      .i_ready (i_out_ready[j])
    );
  end

endmodule

// ==== mesh_out_arb.sv ====
`timescale 1ns/100ps

`include "mesh_router_config.svh"

module mesh_out_arb (
  input  logic                     clk,
  input  logic                     i_rst_n,
  // Requests and head flits from all inputs
  input  logic [`MR_NUM_PORTS-1:0] i_req,
  input  mesh_router_pkg::flit_t   i_heads [`MR_NUM_PORTS],
  output logic [`MR_NUM_PORTS-1:0] o_grant,  // Pop strobe per input
  // Downstream link
  output mesh_router_pkg::flit_t   o_flit,
  output logic                     o_valid,
  input  logic                     i_ready
);
  import mesh_router_pkg::*;

  localparam int NP = `MR_NUM_PORTS;
  localparam int PW = $clog2(NP);

  arb_state_e    state_q;
  logic [PW-1:0] sel_q;    // Locked input, also round-robin pointer
  logic [PW-1:0] pick;
  logic          found;
  logic          load_en;
  logic          take;
  flit_t         flit_q;
  logic          valid_q;

  // ----------------------------------------
  // Round-robin selection
  // ----------------------------------------
  // Search starts just after the last granted input
  always_comb begin : rr_pick
    int idx;
    pick  = sel_q;
    found = 1'b0;
    for (int k = 1; k <= NP; k++) begin
      idx = (int'(sel_q) + k) % NP;
      if (!found && i_req[idx]) begin
        pick  = PW'(idx);
        found = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Packet lock and output register
  // ----------------------------------------
  assign load_en = !valid_q || i_ready;  // Register empty or draining
  assign take    = (state_q == ARB_LOCKED) && i_req[sel_q] && load_en;

  always_comb begin
    o_grant = '0;
    if (take)
      o_grant[sel_q] = 1'b1;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ARB_IDLE;
      sel_q   <= PW'(NP - 1);  // First search starts at TER
      valid_q <= 1'b0;
    end else begin
      if (take)
        valid_q <= 1'b1;
      else if (i_ready)
        valid_q <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          if (found) begin
            sel_q   <= pick;
            state_q <= ARB_LOCKED;
          end
        end
        ARB_LOCKED: begin
          if (take && i_heads[sel_q].last)
            state_q <= ARB_IDLE;  // Tail loaded, reopen the output
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take)
      flit_q <= i_heads[sel_q];
  end

  assign o_flit  = flit_q;
  assign o_valid = valid_q;

endmodule

// ==== mesh_in_port.sv ====
`timescale 1ns/100ps

`include "mesh_router_config.svh"

module mesh_in_port (
  input  logic                        clk,
  input  logic                        i_rst_n,
  // Upstream link
  input  mesh_router_pkg::flit_t      i_flit,
  input  logic                        i_valid,
  output logic                        o_ready,
  // Routing context
  input  mesh_router_pkg::node_addr_t i_node_addr,
  // Toward the output arbiters
  output mesh_router_pkg::flit_t      o_head,
  output logic [`MR_NUM_PORTS-1:0]    o_req,
  input  logic                        i_pop
);
  import mesh_router_pkg::*;

  localparam int NP    = `MR_NUM_PORTS;
  localparam int DEPTH = `MR_BUFF_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // ----------------------------------------
  // Input FIFO
  // ----------------------------------------
  flit_t         mem [DEPTH];
  logic [AW:0]   wr_ptr;  // Extra bit tells full from empty
  logic [AW:0]   rd_ptr;
  logic          full;
  logic          empty;
  logic          push;

  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign o_ready = !full;
  assign push    = i_valid && o_ready;
  assign o_head  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (i_pop)
        rd_ptr <= rd_ptr + 1'b1;  // Only granted while not empty
    end
  end

  // Storage only
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr[AW-1:0]] <= i_flit;
  end

  // ----------------------------------------
  // Route computation
  // ----------------------------------------
  logic [`MR_ADDR_W-1:0] dst_x;
  logic [`MR_ADDR_W-1:0] dst_y;
  port_e                 route_comb;  // From head and current address
  port_e                 route_q;     // Held for the rest of the packet
  port_e                 route_sel;
  arb_state_e            state_q;

  assign dst_x = o_head.data[`MR_HDR_X_LSB +: `MR_ADDR_W];
  assign dst_y = o_head.data[`MR_HDR_Y_LSB +: `MR_ADDR_W];

  // Dimension order, X first then Y
  always_comb begin
    if (dst_x == i_node_addr.x && dst_y == i_node_addr.y)
      route_comb = PORT_TER;
    else if (dst_x != i_node_addr.x)
      route_comb = (dst_x < i_node_addr.x) ? PORT_WST : PORT_EST;
    else
      route_comb = (dst_y < i_node_addr.y) ? PORT_NOR : PORT_SOU;
  end

  assign route_sel = (state_q == ARB_LOCKED) ? route_q : route_comb;

  // One-hot request, quiet while nothing is buffered
  always_comb begin
    for (int k = 0; k < NP; k++)
      o_req[k] = !empty && (route_sel == port_e'(k));
  end

  // Latch the header's choice until its last flit leaves
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ARB_IDLE;
      route_q <= PORT_TER;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (!empty) begin
            route_q <= route_comb;
            if (!(i_pop && o_head.last))
              state_q <= ARB_LOCKED;
          end
        end
        ARB_LOCKED: begin
          if (i_pop && o_head.last)
            state_q <= ARB_IDLE;  // Next head is a new header
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

endmodule

// ==== mesh_node_cfg.sv ====
`timescale 1ns/100ps

`include "mesh_router_config.svh"

module mesh_node_cfg (
  input  logic                        clk,
  input  logic                        i_rst_n,
  input  logic                        i_cfg_wr,
  input  mesh_router_pkg::node_addr_t i_cfg_addr,
  output mesh_router_pkg::node_addr_t o_node_addr
);
  import mesh_router_pkg::*;

  node_addr_t addr_q;  // Current X/Y of this node

  // ----------------------------------------
  // Address register
  // ----------------------------------------
  // A write lands on the strobe edge, so the next header
  // entering route computation sees the new address
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      addr_q.x <= `MR_ADDR_W'(`MR_RESET_X);
      addr_q.y <= `MR_ADDR_W'(`MR_RESET_Y);
    end else if (i_cfg_wr) begin
      addr_q <= i_cfg_addr;
    end
  end

  // Shared by all five input ports
  assign o_node_addr = addr_q;

endmodule

// ==== mesh_router_pkg.sv ====
`include "mesh_router_config.svh"

package mesh_router_pkg;

  // One flit on a router link
  typedef struct packed {
    logic [`MR_DATA_W-1:0] data;
    logic                  last;  // Marks the tail of a packet
  } flit_t;

  // Mesh coordinate of a node
  typedef struct packed {
    logic [`MR_ADDR_W-1:0] x;
    logic [`MR_ADDR_W-1:0] y;
  } node_addr_t;

  // Port numbering, also the index of every port array
  typedef enum logic [2:0] {
    PORT_TER = 3'd0,
    PORT_WST = 3'd1,
    PORT_EST = 3'd2,
    PORT_NOR = 3'd3,
    PORT_SOU = 3'd4
  } port_e;

  // Packet lock state for route holder and output arbiter
  typedef enum logic {
    ARB_IDLE   = 1'b0,
    ARB_LOCKED = 1'b1
  } arb_state_e;

endpackage

// ==== mesh_router_config.svh ====
`ifndef MESH_ROUTER_CONFIG_SVH
`define MESH_ROUTER_CONFIG_SVH

// ----------------------------------------
// Datapath sizing
// ----------------------------------------
`define MR_DATA_W      32   // Flit payload width
`define MR_ADDR_W      2    // One coordinate, 4x4 mesh
`define MR_BUFF_DEPTH  4    // Input FIFO entries, power of two
`define MR_NUM_PORTS   5    // TER, WST, EST, NOR, SOU

// Node address after reset
`define MR_RESET_X     1
`define MR_RESET_Y     2

// ----------------------------------------
// Header flit field positions
// ----------------------------------------
`define MR_HDR_X_LSB   0    // Destination X
`define MR_HDR_Y_LSB   2    // Destination Y
`define MR_HDR_SRC_LSB 4    // Source tag, 4 bits

`endif
